/* all.f */
+incdir+source
source/nnPkg.sv
source/nnNode.sv
source/nnLayer.sv
source/nnArgmax.sv
source/nnTop.sv
verification/nnTop_chk.sv
verification/nnTopTb.sv

/* source/nnArgmax.sv */
`timescale 1ns/1ps
`include "nn_config.svh"

module nnArgmax (
	input logic clk,
	input logic reset,
	input nnPkg::nnData [`NN_CLASSES-1:0] scores,
	input logic scoreValid,
	output logic [1:0] classIndex,
	output nnPkg::nnData classScore,
	output logic classValid
);
	import nnPkg::*;

	logic [1:0] bestIndex;
	nnData bestScore;

	// Signed search over the class scores.
	always_comb
	begin
		bestIndex = '0;
		bestScore = scores[0];
		for (int c = 1; c < `NN_CLASSES; c++)
		begin
			if (scores[c] > bestScore)   // Strict, so a tie keeps the lower index.
			begin
				bestIndex = 2'(c);
				bestScore = scores[c];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			classIndex <= '0;
			classScore <= '0;
			classValid <= 1'b0;
		end
		else
		begin
			classValid <= scoreValid;
			if (scoreValid)
			begin
				classIndex <= bestIndex;   // Holds the last winner between vectors.
				classScore <= bestScore;
			end
		end
	end

endmodule

/* source/nnLayer.sv */
`timescale 1ns/1ps
`include "nn_config.svh"

module nnLayer #(
	parameter int FAN_IN = `NN_INPUTS,
	parameter int NODES = `NN_HIDDEN,
	parameter logic [NODES*FAN_IN*`NN_DATA_W-1:0] WEIGHTS = '0,
	parameter logic [NODES*`NN_DATA_W-1:0] BIASES = '0,
	parameter nnPkg::nnActivation ACTIVATION = nnPkg::actRelu
) (
	input logic clk,
	input logic reset,
	input nnPkg::nnData [FAN_IN-1:0] inputs,
	input logic inValid,
	output nnPkg::nnData [NODES-1:0] outputs,
	output logic outValid
);
	import nnPkg::*;

	localparam int ROW_W = FAN_IN * `NN_DATA_W;

	logic [`NN_NODE_LAT-1:0] validPipe;   // One bit per neuron stage.
	nnData [NODES-1:0] nodeResults;

	genvar k;

	// All neurons see the same vector and differ only in their constants.
	generate
		for (k = 0; k < NODES; k++)
		begin : nodeGen
			nnNode #(
				.FAN_IN(FAN_IN),
				.WEIGHTS(WEIGHTS[k*ROW_W +: ROW_W]),
				.BIAS(BIASES[k*`NN_DATA_W +: `NN_DATA_W]),
				.ACTIVATION(ACTIVATION)
			) node_i (
				.clk(clk),
				.reset(reset),
				.inputs(inputs),
				.result(nodeResults[k])
			);
		end
	endgenerate

	// Strobe follows the data through the same number of registers.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			validPipe <= '0;
		end
		else
		begin
			validPipe <= {validPipe[`NN_NODE_LAT-2:0], inValid};
		end
	end

	assign outputs = nodeResults;
	assign outValid = validPipe[`NN_NODE_LAT-1];

endmodule

/* source/nnNode.sv */
`timescale 1ns/1ps
`include "nn_config.svh"

module nnNode #(
	parameter int FAN_IN = `NN_INPUTS,
	parameter logic [FAN_IN*`NN_DATA_W-1:0] WEIGHTS = '0,
	parameter nnPkg::nnData BIAS = '0,
	parameter nnPkg::nnActivation ACTIVATION = nnPkg::actRelu
) (
	input logic clk,
	input logic reset,
	input nnPkg::nnData [FAN_IN-1:0] inputs,
	output nnPkg::nnData result
);
	import nnPkg::*;

	nnData [FAN_IN-1:0] inputsReg;   // Stage 1.
	nnData [FAN_IN-1:0] products;
	nnData sumNext;
	nnData sumReg;                   // Stage 2.
	nnData activated;

	genvar j;

	// Each product keeps only its low byte.
	generate
		for (j = 0; j < FAN_IN; j++)
		begin : productGen
			nnData weight;

			assign weight = WEIGHTS[j*`NN_DATA_W +: `NN_DATA_W];
			assign products[j] = inputsReg[j] * weight;   // Truncated to 8 bits.
		end
	endgenerate

	// Wrap-around accumulation, bias first.
	always_comb
	begin
		sumNext = BIAS;
		for (int i = 0; i < FAN_IN; i++)
		begin
			sumNext = sumNext + products[i];
		end
	end

	always_comb
	begin
		case (ACTIVATION)
			actRelu:
			begin
				activated = sumReg[`NN_DATA_W-1] ? '0 : sumReg;   // Negative sums clamp.
			end
			actLinear:
			begin
				activated = sumReg;
			end
			default:
			begin
				activated = sumReg;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			inputsReg <= '0;
			sumReg <= '0;
			result <= '0;
		end
		else
		begin
			inputsReg <= inputs;
			sumReg <= sumNext;
			result <= activated;   // Stage 3.
		end
	end

endmodule

/* source/nnPkg.sv */
`include "nn_config.svh"

package nnPkg;

	// One feature, weight, sum or score.
	typedef logic signed [`NN_DATA_W-1:0] nnData;

	// Activation applied by every neuron of a layer.
	typedef enum logic
	{
		actRelu,
		actLinear
	} nnActivation;

endpackage

/* source/nnTop.sv */
`timescale 1ns/1ps
`include "nn_config.svh"
`include "nnWeights.svh"

module nnTop (
	input logic clk,
	input logic reset,
	input nnPkg::nnData [`NN_INPUTS-1:0] features,
	input logic inValid,
	output nnPkg::nnData [`NN_CLASSES-1:0] scores,
	output logic [1:0] classIndex,
	output nnPkg::nnData classScore,
	output logic classValid
);
	import nnPkg::*;

	nnData [`NN_HIDDEN-1:0] hiddenOut;
	logic hiddenValid;
	logic scoreValid;   // Scores are valid one cycle before classValid.

	// Ten features into four ReLU neurons.
	nnLayer #(
		.FAN_IN(`NN_INPUTS),
		.NODES(`NN_HIDDEN),
		.WEIGHTS(`HIDDEN_WEIGHTS),
		.BIASES(`HIDDEN_BIAS),
		.ACTIVATION(actRelu)
	) hiddenLayer (
		.clk(clk),
		.reset(reset),
		.inputs(features),
		.inValid(inValid),
		.outputs(hiddenOut),
		.outValid(hiddenValid)
	);

	// Linear output so class scores keep their sign.
	nnLayer #(
		.FAN_IN(`NN_HIDDEN),
		.NODES(`NN_CLASSES),
		.WEIGHTS(`OUTPUT_WEIGHTS),
		.BIASES(`OUTPUT_BIAS),
		.ACTIVATION(actLinear)
	) outputLayer (
		.clk(clk),
		.reset(reset),
		.inputs(hiddenOut),
		.inValid(hiddenValid),
		.outputs(scores),
		.outValid(scoreValid)
	);

	nnArgmax argmax_i (
		.clk(clk),
		.reset(reset),
		.scores(scores),
		.scoreValid(scoreValid),
		.classIndex(classIndex),
		.classScore(classScore),
		.classValid(classValid)
	);

endmodule

/* source/nnWeights.svh */
`ifndef NN_WEIGHTS_SVH
`define NN_WEIGHTS_SVH

// Weight j of neuron k sits at slice k*FAN_IN+j, so each row is written
// with its highest input first and the rows run from the last neuron down.

// Hidden layer, ten weights per neuron.
`define NN_HIDDEN_ROW3 {8'h12, 8'hE7, 8'h05, 8'h3C, 8'hF1, 8'h29, 8'hC8, 8'h0E, 8'h51, 8'hDA}
`define NN_HIDDEN_ROW2 {8'hF6, 8'h33, 8'hA2, 8'h1B, 8'h07, 8'hE0, 8'h44, 8'hD3, 8'h0C, 8'h6E}
`define NN_HIDDEN_ROW1 {8'h2D, 8'hC1, 8'h5A, 8'hF9, 8'h13, 8'h8B, 8'h26, 8'h71, 8'hEE, 8'h09}
`define NN_HIDDEN_ROW0 {8'h64, 8'h18, 8'hD9, 8'h9F, 8'h6B, 8'h0A, 8'hBF, 8'h19, 8'h47, 8'hFC}

`define HIDDEN_WEIGHTS { \
	`NN_HIDDEN_ROW3, \
	`NN_HIDDEN_ROW2, \
	`NN_HIDDEN_ROW1, \
	`NN_HIDDEN_ROW0 \
}

// Neurons 0 and 2 start negative and clamp to zero on an all-zero input.
`define HIDDEN_BIAS {8'h0B, 8'hF4, 8'h1E, 8'hFA}

// Output layer, four weights per class.
`define NN_OUTPUT_ROW2 {8'hE3, 8'h2A, 8'h71, 8'hC6}
`define NN_OUTPUT_ROW1 {8'h19, 8'hD4, 8'hF2, 8'h3B}
`define NN_OUTPUT_ROW0 {8'h47, 8'h0D, 8'hB5, 8'h28}

`define OUTPUT_WEIGHTS { \
	`NN_OUTPUT_ROW2, \
	`NN_OUTPUT_ROW1, \
	`NN_OUTPUT_ROW0 \
}

// Class biases with class 2 first.
`define OUTPUT_BIAS {8'hF8, 8'h05, 8'hEC}

`endif

/* source/nn_config.svh */
`ifndef NN_CONFIG_SVH
`define NN_CONFIG_SVH

// Width of features, weights, sums and scores.
`define NN_DATA_W 8

// Layer sizes.
`define NN_INPUTS 10
`define NN_HIDDEN 4
`define NN_CLASSES 3

// Input register, sum register and activation register.
`define NN_NODE_LAT 3

// Two layers plus the argmax register.
`define NN_TOP_LAT 7

`endif

/* verification/nnTopTb.sv */
`timescale 1ns/1ps
`include "nn_config.svh"
`include "nnWeights.svh"

module nnTopTb;
	import nnPkg::*;

	localparam int W = `NN_DATA_W;
	localparam logic [`NN_HIDDEN*`NN_INPUTS*W-1:0] HIDDEN_W = `HIDDEN_WEIGHTS;
	localparam logic [`NN_HIDDEN*W-1:0] HIDDEN_B = `HIDDEN_BIAS;
	localparam logic [`NN_CLASSES*`NN_HIDDEN*W-1:0] OUTPUT_W = `OUTPUT_WEIGHTS;
	localparam logic [`NN_CLASSES*W-1:0] OUTPUT_B = `OUTPUT_BIAS;

	logic clk;
	logic reset;
	nnData [`NN_INPUTS-1:0] features;
	logic inValid;
	nnData [`NN_CLASSES-1:0] scores;
	logic [1:0] classIndex;
	nnData classScore;
	logic classValid;

	logic [31:0] lcgState = 32'd39;
	logic [`NN_CLASSES*W-1:0] expScoresQ[$];   // One entry per vector in flight.
	logic [`NN_CLASSES*W-1:0] prevScores;

	nnTop nnTop_i (
		.clk(clk),
		.reset(reset),
		.features(features),
		.inValid(inValid),
		.scores(scores),
		.classIndex(classIndex),
		.classScore(classScore),
		.classValid(classValid)
	);

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#2 clk = ~clk;
		end
	end

	function automatic logic [7:0] nextRandom();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState[31:24];
	endfunction

	function automatic logic [`NN_INPUTS*W-1:0] randomVector();
		logic [`NN_INPUTS*W-1:0] vec;
		for (int i = 0; i < `NN_INPUTS; i++)
		begin
			vec[i*W +: W] = nextRandom();
		end
		return vec;
	endfunction

	// Products keep their low byte and every sum wraps at 8 bits.
	function automatic logic [`NN_CLASSES*W-1:0] modelScores(input logic [`NN_INPUTS*W-1:0] vec);
		logic [`NN_HIDDEN*W-1:0] hidden;
		logic [`NN_CLASSES*W-1:0] classScores;
		logic signed [2*W-1:0] product;
		logic [W-1:0] acc;
		for (int k = 0; k < `NN_HIDDEN; k++)
		begin
			acc = HIDDEN_B[k*W +: W];
			for (int j = 0; j < `NN_INPUTS; j++)
			begin
				product = $signed(vec[j*W +: W]) * $signed(HIDDEN_W[(k*`NN_INPUTS+j)*W +: W]);
				acc = acc + product[W-1:0];
			end
			hidden[k*W +: W] = acc[W-1] ? '0 : acc;   // ReLU.
		end
		for (int c = 0; c < `NN_CLASSES; c++)
		begin
			acc = OUTPUT_B[c*W +: W];
			for (int k = 0; k < `NN_HIDDEN; k++)
			begin
				product = $signed(hidden[k*W +: W]) * $signed(OUTPUT_W[(c*`NN_HIDDEN+k)*W +: W]);
				acc = acc + product[W-1:0];
			end
			classScores[c*W +: W] = acc;   // Linear.
		end
		return classScores;
	endfunction

	function automatic logic [1:0] modelClass(input logic [`NN_CLASSES*W-1:0] s);
		logic [1:0] best;
		best = 2'd0;
		for (int c = 1; c < `NN_CLASSES; c++)
		begin
			if ($signed(s[c*W +: W]) > $signed(s[best*W +: W]))   // Lowest index wins a tie.
			begin
				best = 2'(c);
			end
		end
		return best;
	endfunction

	task automatic stopWithFailure(input string reason);
		$display("%s", reason);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected)
		begin
			stopWithFailure($sformatf("[ERROR] time %0t: %s expected %0h, got %0h",
				$time, what, expected, actual));
		end
	endtask

	// Scores lead classValid by one cycle.
	always @(negedge clk)
	begin : resultMonitor
		logic [`NN_CLASSES*W-1:0] expScores;
		logic [1:0] expIndex;
		if (!reset && classValid)
		begin
			if (expScoresQ.size() == 0)
			begin
				stopWithFailure("A classValid strobe arrived with no vector in flight");
			end
			else
			begin
				expScores = expScoresQ.pop_front();
				expIndex = modelClass(expScores);
				checkValue(prevScores, expScores, "scores");
				checkValue(classIndex, expIndex, "classIndex");
				checkValue($unsigned(classScore), expScores[expIndex*W +: W], "classScore");
			end
		end
		prevScores = scores;
	end

	task automatic sendVector(input logic [`NN_INPUTS*W-1:0] vec);
		@(posedge clk);
		features <= vec;
		inValid <= 1'b1;
		expScoresQ.push_back(modelScores(vec));
	endtask

	task automatic idleCycles(input int n);
		repeat (n)
		begin
			@(posedge clk);
			inValid <= 1'b0;
		end
	endtask

	task automatic drainResults(input int maxCycles);
		int cycles;
		cycles = 0;
		while (expScoresQ.size() != 0)
		begin
			if (cycles == maxCycles)
			begin
				stopWithFailure("Timeout: no result arrived for a vector still in flight");
			end
			else
			begin
				@(negedge clk);
				cycles++;
			end
		end
	endtask

	task automatic testReset();
		@(negedge clk);
		checkValue(classValid, 0, "classValid after reset");
		checkValue(classIndex, 0, "classIndex after reset");
		checkValue($unsigned(classScore), 0, "classScore after reset");
		checkValue(scores, 0, "scores after reset");
		repeat (10)
		begin
			@(negedge clk);
			checkValue(classValid, 0, "classValid while idle");
		end
	endtask

	task automatic testZeroVector();
		int cycles;
		sendVector('0);
		idleCycles(1);
		cycles = 0;
		while (classValid !== 1'b1)
		begin
			if (cycles == 4 * `NN_TOP_LAT)
			begin
				stopWithFailure("Timeout: no result arrived for the zero vector");
			end
			else
			begin
				@(negedge clk);
				cycles++;
			end
		end
		checkValue(cycles, `NN_TOP_LAT, "classValid latency");
		drainResults(5);
	endtask

	task automatic testDirected();
		logic [`NN_INPUTS*W-1:0] vec;
		for (int p = 0; p < 5; p++)
		begin
			for (int i = 0; i < `NN_INPUTS; i++)
			begin
				case (p)
					0: vec[i*W +: W] = 8'h7F;
					1: vec[i*W +: W] = 8'h80;   // Most negative feature.
					2: vec[i*W +: W] = i[0] ? 8'h80 : 8'h7F;
					3: vec[i*W +: W] = i[0] ? 8'hC0 : 8'h40;
					default: vec[i*W +: W] = (i == 3) ? 8'h7F : 8'h00;
				endcase
			end
			sendVector(vec);
			idleCycles(2);
		end
		drainResults(20);
	endtask

	task automatic testRandom(input int count, input bit withGaps);
		for (int n = 0; n < count; n++)
		begin
			sendVector(randomVector());
			if (withGaps)
			begin
				idleCycles(nextRandom() % 4);
			end
		end
		idleCycles(1);
		drainResults(40);
		// A late strobe here would have no vector behind it.
		repeat (`NN_TOP_LAT)
		begin
			@(negedge clk);
			checkValue(classValid, 0, "classValid after the last result");
		end
	endtask

	initial
	begin
		reset = 1'b1;
		inValid = 1'b1;   // Held high during reset and kept out of the pipeline.
		features = '1;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		inValid <= 1'b0;
		features <= '0;
		testReset();
		testZeroVector();
		testDirected();
		testRandom(50, 1'b0);
		testRandom(30, 1'b1);
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

/* verification/nnTop_chk.sv */
`timescale 1ns/1ps
`include "nn_config.svh"

module nnTop_chk (
	input logic clk,
	input logic reset,
	input logic inValid,
	input nnPkg::nnData [`NN_CLASSES-1:0] scores,
	input nnPkg::nnData classScore,
	input logic classValid
);
	import nnPkg::*;

	logic [3:0] sinceReset;   // Saturates once the delay line holds only post-reset strobes.

	genvar c;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			sinceReset <= '0;
		end
		else if (sinceReset < `NN_TOP_LAT)
		begin
			sinceReset <= sinceReset + 4'd1;
		end
	end

	validKnown: assert property (@(posedge clk) disable iff (reset)
		!$isunknown(classValid))
		else $error("classValid is unknown after reset");

	validLatency: assert property (@(posedge clk) disable iff (reset)
		(sinceReset == `NN_TOP_LAT) |-> (classValid == $past(inValid, `NN_TOP_LAT)))
		else $error("classValid does not follow inValid by the pipeline latency");

	generate
		for (c = 0; c < `NN_CLASSES; c++)
		begin : scoreGen
			scoreIsMax: assert property (@(posedge clk) disable iff (reset)
				classValid |-> (classScore >= $past(scores[c])))
				else $error("classScore is below class score %0d", c);
		end
	endgenerate

endmodule

bind nnTop nnTop_chk nnTop_chk_i (
	.clk(clk),
	.reset(reset),
	.inValid(inValid),
	.scores(scores),
	.classScore(classScore),
	.classValid(classValid)
);
